// File: sim/core_stimulus.txt
# I <instruction word hex>
# W <expected rd hex> <expected data hex>, writebacks in program order
# immediate group and lui
I 12300093
W 1 00000123
I FFB00113
W 2 FFFFFFFB
I 800011B7
W 3 80001000
I 0F00C213
W 4 000001D3
I 00F16293
W 5 FFFFFFFF
I 7F017313
W 6 000007F0
I 00112393
W 7 00000001
I 00113413
W 8 00000000
I 00409493
W 9 00001230
I 0081D513
W a 00800010
I 4081D593
W b FF800010
I FFF0B613
W c 00000001
# register-register group
I 002086B3
W d 0000011E
I 40208733
W e 00000128
I 0021F7B3
W f 80001000
I 009260B3
W 1 000013F3
I 0032C133
W 2 7FFFEFFF
I 0011A233
W 4 00000001
I 0011B2B3
W 5 00000000
I 00409333
W 6 000027E6
I 0061D3B3
W 7 02000040
I 4061D433
W 8 FE000040
# dependent chain
I 00148493
W 9 00001231
I 00148493
W 9 00001232
I 00948533
W a 00002464
I 409505B3
W b 00001232
# x0 targets, x0 reads, a load that is not supported
I 05508013
I 00208033
I 00000633
W c 00000000
I 7AB06693
W d 000007AB
I FFFFF737
W e FFFFF000
I FFF70713
W e FFFFEFFF
I 0000A283
I 000287B3
W f 00000000

// File: sources.f
+incdir+include
src/rv_core_pkg.sv
src/rv_decode_stage.sv
src/rv_regfile_scoreboard.sv
src/rv_execute_stage.sv
src/rv_core.sv
sim/tb_clock_gen.sv
sim/tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f \
    --top-module tb_rv_core \
    -o tb_rv_core_sim

./obj_dir/tb_rv_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: PASS" sim.log; then
    exit 0
else
    exit 1
fi

// File: sim/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    localparam string STIM_PATH     = "sim/core_stimulus.txt";
    localparam int    RESET_TIMEOUT = 20;
    localparam int    READY_TIMEOUT = 100;
    localparam int    RUN_TIMEOUT   = 5000;
    localparam int    DRAIN_CYCLES  = 8;

    logic                   clock;
    logic                   arst_n;
    logic                   i_ins_valid;
    rv_core_pkg::ins_t      i_ins;
    logic                   o_ins_ready;
    logic                   o_wb_valid;
    rv_core_pkg::reg_addr_t o_wb_rd;
    rv_core_pkg::xlen_t     o_wb_data;

    rv_core_pkg::ins_t      ins_q[$];
    rv_core_pkg::reg_addr_t exp_rd_q[$];
    rv_core_pkg::xlen_t     exp_data_q[$];

    integer seed = 32'h3a7ef4ac;
    int     mismatch_count = 0;
    int     other_errors = 0;
    int     exp_idx = 0;
    logic   drive_done = 1'b0;
    logic   timed_out = 1'b0;

    tb_clock_gen clk_gen_i (
        .o_clock  (clock ),
        .o_arst_n (arst_n)
    );

    rv_core dut_i (
        .clock       (clock      ),
        .i_arst_n    (arst_n     ),
        .i_ins_valid (i_ins_valid),
        .i_ins       (i_ins      ),
        .o_ins_ready (o_ins_ready),
        .o_wb_valid  (o_wb_valid ),
        .o_wb_rd     (o_wb_rd    ),
        .o_wb_data   (o_wb_data  )
    );

    task automatic check_rd(input rv_core_pkg::reg_addr_t got, input rv_core_pkg::reg_addr_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch o_wb_rd: got %h expected %h (writeback %0d)", got, exp, exp_idx);
        end
    endtask

    task automatic check_data(input rv_core_pkg::xlen_t got, input rv_core_pkg::xlen_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch o_wb_data: got %h expected %h (writeback %0d)", got, exp, exp_idx);
        end
    endtask

    task automatic load_stimulus();
        int                fd;
        int                code;
        logic [7:0]        kind;
        logic [31:0]       word;
        logic [31:0]       rd_val;
        logic [31:0]       data_val;
        logic [8*160-1:0]  rest;
        fd = $fopen(STIM_PATH, "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open the stimulus file %s", STIM_PATH);
            return;
        end
        code = $fscanf(fd, " %c", kind);
        while (code == 1) begin
            if (kind == "#") begin
                code = $fgets(rest, fd);
            end else if (kind == "I") begin
                code = $fscanf(fd, "%h", word);
                ins_q.push_back(word);
            end else if (kind == "W") begin
                code = $fscanf(fd, "%h %h", rd_val, data_val);
                exp_rd_q.push_back(rv_core_pkg::reg_addr_t'(rd_val));
                exp_data_q.push_back(data_val);
            end else begin
                other_errors++;
                $display("unknown record kind '%c' in the stimulus file", kind);
            end
            code = $fscanf(fd, " %c", kind);
        end
        $fclose(fd);
        if (ins_q.size() == 0) begin
            other_errors++;
            $display("the stimulus file holds no instructions");
        end
    endtask

    // leaves the caller 2 ns after a rising edge with reset released
    task automatic wait_reset();
        int cnt;
        cnt = 0;
        @(posedge clock);
        while (!arst_n && cnt < RESET_TIMEOUT) begin
            @(posedge clock);
            cnt++;
        end
        if (!arst_n) begin
            other_errors++;
            timed_out = 1'b1;
            $display("timeout: reset was never released");
        end
        #2;
    endtask

    task automatic check_idle();
        repeat (2) begin
            @(negedge clock);
            if (o_wb_valid !== 1'b0) begin
                other_errors++;
                $display("writeback strobe is high after reset with no instruction sent");
            end
            if (o_ins_ready !== 1'b1) begin
                other_errors++;
                $display("instruction port is not ready after reset");
            end
        end
        @(posedge clock);
        #2;
    endtask

    task automatic drive_program();
        int gap;
        int cnt;
        for (int i = 0; i < ins_q.size(); i++) begin
            if (timed_out) begin
                break;
            end
            gap = {$random(seed)} % 4;
            repeat (gap) begin
                @(posedge clock);
                #2;
            end
            i_ins_valid = 1'b1;
            i_ins       = ins_q[i];
            // ready is stable mid-cycle, the transfer happens at the next edge
            cnt = 0;
            @(negedge clock);
            while (!o_ins_ready && cnt < READY_TIMEOUT) begin
                @(negedge clock);
                cnt++;
            end
            if (!o_ins_ready) begin
                other_errors++;
                timed_out = 1'b1;
                $display("timeout: instruction %0d was never accepted", i);
            end
            @(posedge clock);
            #2;
            i_ins_valid = 1'b0;
            i_ins       = '0;
        end
        drive_done = 1'b1;
    endtask

    task automatic watch_writebacks();
        int cycles;
        int quiet;
        cycles = 0;
        quiet  = 0;
        while (!timed_out &&
               !(drive_done && exp_idx == exp_rd_q.size() && quiet >= DRAIN_CYCLES)) begin
            @(negedge clock);
            cycles++;
            if (o_wb_valid) begin
                quiet = 0;
                if (exp_idx < exp_rd_q.size()) begin
                    check_rd(o_wb_rd, exp_rd_q[exp_idx]);
                    check_data(o_wb_data, exp_data_q[exp_idx]);
                    exp_idx++;
                end else begin
                    other_errors++;
                    $display("unexpected extra writeback to x%0d", o_wb_rd);
                end
            end else begin
                quiet++;
            end
            if (cycles >= RUN_TIMEOUT) begin
                other_errors++;
                timed_out = 1'b1;
                $display("timeout: %0d of %0d writebacks seen", exp_idx, exp_rd_q.size());
            end
        end
    endtask

    initial begin
        i_ins_valid = 1'b0;
        i_ins       = '0;
        load_stimulus();
        if (other_errors == 0) begin
            wait_reset();
            if (!timed_out) begin
                check_idle();
                fork
                    drive_program();
                    watch_writebacks();
                join
            end
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 20,
    parameter int RESET_CYCLES   = 2
) (
    output logic o_clock,
    output logic o_arst_n
);

    initial begin
        o_clock = 1'b0;
        forever #(HALF_PERIOD_NS) o_clock = ~o_clock;
    end

    // release a little after the edge so no flop sees it change
    initial begin
        o_arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clock);
        #2;
        o_arst_n = 1'b1;
    end

endmodule

// File: src/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic                   clock,
    input  logic                   i_arst_n,
    input  logic                   i_ins_valid,
    input  rv_core_pkg::ins_t      i_ins,
    output logic                   o_ins_ready,
    output logic                   o_wb_valid,
    output rv_core_pkg::reg_addr_t o_wb_rd,
    output rv_core_pkg::xlen_t     o_wb_data
);

    rv_core_pkg::reg_addr_t rs1_addr;
    rv_core_pkg::reg_addr_t rs2_addr;
    rv_core_pkg::xlen_t     rs1_data;
    rv_core_pkg::xlen_t     rs2_data;
    logic                   rs1_busy;
    logic                   rs2_busy;
    logic                   mark_busy;

    // decode to execute
    logic                   issue_valid;
    logic                   issue_ready;
    rv_core_pkg::xlen_t     issue_src1;
    rv_core_pkg::xlen_t     issue_src2;
    rv_core_pkg::xlen_t     issue_imm;
    logic                   issue_use_imm;
    rv_core_pkg::alu_op_e   issue_alu_op;
    rv_core_pkg::reg_addr_t issue_rd;
    logic                   issue_wen;

    rv_decode_stage u_decode (
        .clock         (clock        ),
        .i_arst_n      (i_arst_n     ),
        .i_ins_valid   (i_ins_valid  ),
        .i_ins         (i_ins        ),
        .i_issue_ready (issue_ready  ),
        .i_rs1_data    (rs1_data     ),
        .i_rs2_data    (rs2_data     ),
        .i_rs1_busy    (rs1_busy     ),
        .i_rs2_busy    (rs2_busy     ),
        .o_ins_ready   (o_ins_ready  ),
        .o_rs1_addr    (rs1_addr     ),
        .o_rs2_addr    (rs2_addr     ),
        .o_issue_valid (issue_valid  ),
        .o_src1        (issue_src1   ),
        .o_src2        (issue_src2   ),
        .o_imm         (issue_imm    ),
        .o_use_imm     (issue_use_imm),
        .o_alu_op      (issue_alu_op ),
        .o_rd          (issue_rd     ),
        .o_wen         (issue_wen    ),
        .o_mark_busy   (mark_busy    )
    );

    // writeback register drives both the write port and the core outputs
    rv_regfile_scoreboard u_regfile (
        .clock       (clock     ),
        .i_arst_n    (i_arst_n  ),
        .i_rs1_addr  (rs1_addr  ),
        .i_rs2_addr  (rs2_addr  ),
        .i_mark_busy (mark_busy ),
        .i_mark_rd   (issue_rd  ),
        .i_wr_en     (o_wb_valid),
        .i_wr_addr   (o_wb_rd   ),
        .i_wr_data   (o_wb_data ),
        .o_rs1_data  (rs1_data  ),
        .o_rs2_data  (rs2_data  ),
        .o_rs1_busy  (rs1_busy  ),
        .o_rs2_busy  (rs2_busy  )
    );

    rv_execute_stage u_execute (
        .clock         (clock        ),
        .i_arst_n      (i_arst_n     ),
        .i_issue_valid (issue_valid  ),
        .i_src1        (issue_src1   ),
        .i_src2        (issue_src2   ),
        .i_imm         (issue_imm    ),
        .i_use_imm     (issue_use_imm),
        .i_alu_op      (issue_alu_op ),
        .i_rd          (issue_rd     ),
        .i_wen         (issue_wen    ),
        .o_issue_ready (issue_ready  ),
        .o_wb_valid    (o_wb_valid   ),
        .o_wb_rd       (o_wb_rd      ),
        .o_wb_data     (o_wb_data    )
    );

endmodule

// File: src/rv_execute_stage.sv
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_execute_stage (
    input  logic                   clock,
    input  logic                   i_arst_n,
    input  logic                   i_issue_valid,
    input  rv_core_pkg::xlen_t     i_src1,
    input  rv_core_pkg::xlen_t     i_src2,
    input  rv_core_pkg::xlen_t     i_imm,
    input  logic                   i_use_imm,
    input  rv_core_pkg::alu_op_e   i_alu_op,
    input  rv_core_pkg::reg_addr_t i_rd,
    input  logic                   i_wen,
    output logic                   o_issue_ready,
    output logic                   o_wb_valid,
    output rv_core_pkg::reg_addr_t o_wb_rd,
    output rv_core_pkg::xlen_t     o_wb_data
);

    localparam int SHAMT_W = $clog2(`RV_XLEN);

    logic                   issue_fire;
    logic                   ex_valid;
    rv_core_pkg::xlen_t     ex_src1;
    rv_core_pkg::xlen_t     ex_src2;
    rv_core_pkg::xlen_t     ex_imm;
    logic                   ex_use_imm;
    rv_core_pkg::alu_op_e   ex_alu_op;
    rv_core_pkg::reg_addr_t ex_rd;
    logic                   ex_wen;
    rv_core_pkg::xlen_t     op_b;
    logic [SHAMT_W-1:0]     shamt;
    logic                   lt_signed;
    logic                   lt_unsigned;
    rv_core_pkg::xlen_t     alu_res;

    // writeback has no back-pressure
    assign o_issue_ready = 1'b1;
    assign issue_fire    = i_issue_valid && o_issue_ready;

    // decode-to-execute register
    always_ff @(posedge clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= issue_fire;
        end
    end

    always_ff @(posedge clock) begin
        if (issue_fire) begin
            ex_src1    <= i_src1;
            ex_src2    <= i_src2;
            ex_imm     <= i_imm;
            ex_use_imm <= i_use_imm;
            ex_alu_op  <= i_alu_op;
            ex_rd      <= i_rd;
            ex_wen     <= i_wen;
        end
    end

    assign op_b        = ex_use_imm ? ex_imm : ex_src2;
    assign shamt       = op_b[SHAMT_W-1:0];
    assign lt_signed   = $signed(ex_src1) < $signed(op_b);
    assign lt_unsigned = ex_src1 < op_b;

    always_comb begin
        case (ex_alu_op)
            rv_core_pkg::alu_add:    alu_res = ex_src1 + op_b;
            rv_core_pkg::alu_sub:    alu_res = ex_src1 - op_b;
            rv_core_pkg::alu_and:    alu_res = ex_src1 & op_b;
            rv_core_pkg::alu_or:     alu_res = ex_src1 | op_b;
            rv_core_pkg::alu_xor:    alu_res = ex_src1 ^ op_b;
            rv_core_pkg::alu_slt:    alu_res = {{(`RV_XLEN-1){1'b0}}, lt_signed};
            rv_core_pkg::alu_sltu:   alu_res = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
            rv_core_pkg::alu_sll:    alu_res = ex_src1 << shamt;
            rv_core_pkg::alu_srl:    alu_res = ex_src1 >> shamt;
            rv_core_pkg::alu_sra:    alu_res = $signed(ex_src1) >>> shamt;
            rv_core_pkg::alu_pass_b: alu_res = op_b;
            default:                 alu_res = '0;
        endcase
    end

    // execute-to-writeback register
    always_ff @(posedge clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_wb_valid <= 1'b0;
        end else begin
            o_wb_valid <= ex_valid && ex_wen;
        end
    end

    always_ff @(posedge clock) begin
        if (ex_valid) begin
            o_wb_rd   <= ex_rd;
            o_wb_data <= alu_res;
        end
    end

    // x0 writes are dropped back in decode
    ast_no_x0_writeback : assert property (
        @(posedge clock) disable iff (!i_arst_n)
        o_wb_valid |-> o_wb_rd != '0
    ) else $error("writeback to x0");

endmodule

// File: src/rv_regfile_scoreboard.sv
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_regfile_scoreboard (
    input  logic                   clock,
    input  logic                   i_arst_n,
    input  rv_core_pkg::reg_addr_t i_rs1_addr,
    input  rv_core_pkg::reg_addr_t i_rs2_addr,
    input  logic                   i_mark_busy,
    input  rv_core_pkg::reg_addr_t i_mark_rd,
    input  logic                   i_wr_en,
    input  rv_core_pkg::reg_addr_t i_wr_addr,
    input  rv_core_pkg::xlen_t     i_wr_data,
    output rv_core_pkg::xlen_t     o_rs1_data,
    output rv_core_pkg::xlen_t     o_rs2_data,
    output logic                   o_rs1_busy,
    output logic                   o_rs2_busy
);

    // at most two writes per register in flight, execute and writeback
    localparam int CNT_W = 2;

    rv_core_pkg::xlen_t regs [`RV_REG_COUNT];
    logic [CNT_W-1:0]   pend_cnt [`RV_REG_COUNT];
    logic [`RV_REG_COUNT-1:0] set_vec;
    logic [`RV_REG_COUNT-1:0] clr_vec;

    function automatic rv_core_pkg::xlen_t read_data(input rv_core_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        // write-through from the writeback port
        if (i_wr_en && (i_wr_addr == addr)) begin
            return i_wr_data;
        end
        return regs[addr];
    endfunction

    function automatic logic read_busy(input rv_core_pkg::reg_addr_t addr);
        logic hit;
        hit = i_wr_en && (i_wr_addr == addr);
        return (pend_cnt[addr] - CNT_W'(hit)) != '0;
    endfunction

    always_ff @(posedge clock) begin
        if (i_wr_en && (i_wr_addr != '0)) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    always_comb begin
        for (int i = 0; i < `RV_REG_COUNT; i++) begin
            set_vec[i] = i_mark_busy && (i_mark_rd == rv_core_pkg::reg_addr_t'(i));
            clr_vec[i] = i_wr_en && (i_wr_addr == rv_core_pkg::reg_addr_t'(i));
        end
    end

    // pending write count per register, nonzero means busy
    always_ff @(posedge clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                pend_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                if (set_vec[i] && !clr_vec[i]) begin
                    pend_cnt[i] <= pend_cnt[i] + 1'b1;
                end else if (clr_vec[i] && !set_vec[i]) begin
                    pend_cnt[i] <= pend_cnt[i] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        o_rs1_data = read_data(i_rs1_addr);
        o_rs2_data = read_data(i_rs2_addr);
        o_rs1_busy = read_busy(i_rs1_addr);
        o_rs2_busy = read_busy(i_rs2_addr);
    end

    ast_write_was_marked : assert property (
        @(posedge clock) disable iff (!i_arst_n)
        i_wr_en |-> pend_cnt[i_wr_addr] != '0
    ) else $error("write to a register that was never marked busy");

endmodule

// File: src/rv_decode_stage.sv
`timescale 1ns/1ps
`include "rv_core_settings.svh"

module rv_decode_stage (
    input  logic                  clock,
    input  logic                  i_arst_n,
    input  logic                  i_ins_valid,
    input  rv_core_pkg::ins_t     i_ins,
    input  logic                  i_issue_ready,
    input  rv_core_pkg::xlen_t    i_rs1_data,
    input  rv_core_pkg::xlen_t    i_rs2_data,
    input  logic                  i_rs1_busy,
    input  logic                  i_rs2_busy,
    output logic                  o_ins_ready,
    output rv_core_pkg::reg_addr_t o_rs1_addr,
    output rv_core_pkg::reg_addr_t o_rs2_addr,
    output logic                  o_issue_valid,
    output rv_core_pkg::xlen_t    o_src1,
    output rv_core_pkg::xlen_t    o_src2,
    output rv_core_pkg::xlen_t    o_imm,
    output logic                  o_use_imm,
    output rv_core_pkg::alu_op_e  o_alu_op,
    output rv_core_pkg::reg_addr_t o_rd,
    output logic                  o_wen,
    output logic                  o_mark_busy
);

    logic                 ir_valid;
    rv_core_pkg::ins_t    ir_ins;
    logic                 accept;
    logic                 issue_fire;
    logic                 hazard;
    logic                 legal;
    logic                 use_rs1;
    logic                 use_rs2;
    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic [4:0]           rd_field;
    logic [4:0]           rs1_field;
    logic [4:0]           rs2_field;

    function automatic rv_core_pkg::alu_op_e funct_to_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rv_core_pkg::alu_sub : rv_core_pkg::alu_add;
            3'b001:  return rv_core_pkg::alu_sll;
            3'b010:  return rv_core_pkg::alu_slt;
            3'b011:  return rv_core_pkg::alu_sltu;
            3'b100:  return rv_core_pkg::alu_xor;
            3'b101:  return alt ? rv_core_pkg::alu_sra : rv_core_pkg::alu_srl;
            3'b110:  return rv_core_pkg::alu_or;
            default: return rv_core_pkg::alu_and;
        endcase
    endfunction

    assign accept      = i_ins_valid && o_ins_ready;
    assign issue_fire  = o_issue_valid && i_issue_ready;
    assign o_ins_ready = !ir_valid || issue_fire;

    // instruction register between fetch and decode
    always_ff @(posedge clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ir_valid <= 1'b0;
        end else if (accept) begin
            ir_valid <= 1'b1;
        end else if (issue_fire) begin
            ir_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            ir_ins <= i_ins;
        end
    end

    assign opcode    = ir_ins[6:0];
    assign rd_field  = ir_ins[11:7];
    assign funct3    = ir_ins[14:12];
    assign rs1_field = ir_ins[19:15];
    assign rs2_field = ir_ins[24:20];
    assign funct7    = ir_ins[31:25];

    always_comb begin
        legal    = 1'b0;
        use_rs1  = 1'b0;
        use_rs2  = 1'b0;
        o_use_imm = 1'b1;
        o_alu_op = rv_core_pkg::alu_add;
        o_imm    = {{(`RV_XLEN-12){ir_ins[31]}}, ir_ins[31:20]};
        case (opcode)
            `RV_OP_REG: begin
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                o_use_imm = 1'b0;
                o_alu_op  = funct_to_op(funct3, ir_ins[30]);
                legal     = (funct7 == `RV_FUNCT7_BASE) ||
                            ((funct7 == `RV_FUNCT7_ALT) &&
                             (funct3 == 3'b000 || funct3 == 3'b101));
            end
            `RV_OP_IMM: begin
                use_rs1  = 1'b1;
                // only the right shift reads bit 30 as a selector
                o_alu_op = funct_to_op(funct3, (funct3 == 3'b101) && ir_ins[30]);
                case (funct3)
                    3'b001:  legal = (funct7 == `RV_FUNCT7_BASE);
                    3'b101:  legal = (funct7 == `RV_FUNCT7_BASE) ||
                                     (funct7 == `RV_FUNCT7_ALT);
                    default: legal = 1'b1;
                endcase
            end
            `RV_OP_LUI: begin
                o_alu_op = rv_core_pkg::alu_pass_b;
                o_imm    = {ir_ins[31:12], 12'b0};
                legal    = 1'b1;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
        // RV32E has no x16 and up
        if (rd_field[4] || (use_rs1 && rs1_field[4]) || (use_rs2 && rs2_field[4])) begin
            legal = 1'b0;
        end
    end

    assign o_rs1_addr = rs1_field[3:0];
    assign o_rs2_addr = rs2_field[3:0];
    assign o_src1     = i_rs1_data;
    assign o_src2     = i_rs2_data;
    assign o_rd       = rd_field[3:0];
    assign o_wen      = legal && (rd_field != 5'd0);

    // wait in decode while a source still has a write in flight
    assign hazard        = (use_rs1 && i_rs1_busy) || (use_rs2 && i_rs2_busy);
    assign o_issue_valid = ir_valid && !hazard;
    assign o_mark_busy   = issue_fire && o_wen;

    // a refused instruction stays offered and unchanged
    ast_ins_held : assert property (
        @(posedge clock) disable iff (!i_arst_n)
        i_ins_valid && !o_ins_ready |=> i_ins_valid && $stable(i_ins)
    ) else $error("instruction port dropped or changed a refused instruction");

endmodule

// File: src/rv_core_pkg.sv
`include "rv_core_settings.svh"

package rv_core_pkg;

    // operands, immediates and results
    typedef logic [`RV_XLEN-1:0] xlen_t;

    // raw instruction word
    typedef logic [`RV_ILEN-1:0] ins_t;

    // RV32E register index, x0 to x15
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

    // alu operations
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_slt    = 4'd5,
        alu_sltu   = 4'd6,
        alu_sll    = 4'd7,
        alu_srl    = 4'd8,
        alu_sra    = 4'd9,
        // lui passes the U immediate straight through
        alu_pass_b = 4'd10
    } alu_op_e;

endpackage

// File: include/rv_core_settings.svh
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// datapath and register file sizes
`define RV_XLEN        32
`define RV_ILEN        32
`define RV_REG_COUNT   16
`define RV_REG_ADDR_W  4

// opcode field values accepted by decode
`define RV_OP_REG      7'b0110011
`define RV_OP_IMM      7'b0010011
`define RV_OP_LUI      7'b0110111

// funct7 values for the register and shift groups
`define RV_FUNCT7_BASE 7'b0000000
`define RV_FUNCT7_ALT  7'b0100000

`endif
